/* verilog.f */
+incdir+bench
design/barrett_pkg.sv
design/delay_line.sv
design/pipe_multiplier.sv
design/quotient_estimate.sv
design/residue_correct.sv
design/barrett_ctrl.sv
design/barrett_top.sv
bench/barrett_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the Barrett reduction testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f verilog.f \
  --top-module barrett_tb

if ! out=$(./obj_dir/Vbarrett_tb); then
  echo "$out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1

/* bench/barrett_tb_util.svh */
// Included inside barrett_tb, relies on its error counters and DATA_W
// Model valid only for 2 <= m < 2^32 and x < 2^(2k)
`ifndef BARRETT_TB_UTIL_SVH
`define BARRETT_TB_UTIL_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] v;
  v = s;
  v = v ^ (v << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

// k, number of bits needed for m
function automatic int bit_length(input logic [DATA_W-1:0] m);
  int len;
  len = 0;
  while ((m >> len) != '0) begin
    len++;
  end
  return len;
endfunction

// mu = floor(2^(2k) / m), 2^64 needs the wide numerator
function automatic logic [DATA_W-1:0] barrett_mu(input logic [DATA_W-1:0] m);
  logic [127:0] num;
  logic [127:0] quo;
  num = 128'd1 << (2 * bit_length(m));
  quo = num / {64'd0, m};
  return quo[DATA_W-1:0];
endfunction

function automatic logic [DATA_W-1:0] ref_mod(input logic [DATA_W-1:0] x,
                                              input logic [DATA_W-1:0] m);
  return x % m;  // Plain remainder
endfunction

// Clears all bits of x from position bits upward
function automatic logic [DATA_W-1:0] below_pow2(input logic [DATA_W-1:0] x, input int bits);
  logic [127:0] lim;
  lim = (128'd1 << bits) - 128'd1;
  return x & lim[DATA_W-1:0];
endfunction

task automatic check_result(input string name, input logic [DATA_W-1:0] exp_v,
                            input logic [DATA_W-1:0] act_v);
  if (act_v !== exp_v) begin
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
    value_errs++;
  end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
  if (act_v !== exp_v) begin
    $display("CHECK FAILED %s: expected %b, actual %b", name, exp_v, act_v);
    flag_errs++;
  end
endtask

`endif

/* bench/barrett_tb.sv */
// Directed table plus 200 xorshift rows; mu comes from the bench model
// Every result is checked for value, order and fixed start-to-valid latency
`timescale 1ns/100ps
`default_nettype none

module barrett_tb import barrett_pkg::*; ();

  localparam int N_DIR      = 10;
  localparam int N_RAND     = 200;
  localparam int N_ROWS     = N_DIR + N_RAND;
  localparam int MAX_GAP    = 12;  // Longest idle run in the table
  localparam int CLK_PERIOD = 20;
  localparam logic [31:0] SEED = 32'h38ca_2ca6;
  localparam int WD_CYCLES  = N_ROWS * (MAX_GAP + 1) + BARRETT_LATENCY + 50;

  typedef struct packed {
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] m;
    logic [7:0]        gap;    // Idle cycles after this start
    logic [DATA_W-1:0] exp_r;  // x mod m
  } vec_t;

  // Residues worked out by hand
  localparam vec_t DIR_TAB [N_DIR] = '{
    '{64'd5,                   64'd7,            8'd12, 64'd5},            // x < m
    '{64'd1000003,             64'd1000003,      8'd12, 64'd0},            // x = m
    '{64'd4293001440,          64'd65521,        8'd12, 64'd65520},        // m*m - 1
    '{64'h0000_0000_0012_3abc, 64'h1000,         8'd12, 64'habc},          // Power of two
    '{64'd15,                  64'd2,            8'd12, 64'd1},            // Smallest m
    '{64'd14,                  64'd2,            8'd0,  64'd0},
    '{64'hffff_fffe_0000_0000, 64'hffff_ffff,    8'd0,  64'hffff_fffe},    // Widest m, m*m - 1
    '{64'h0000_0001_0000_0004, 64'hffff_ffff,    8'd0,  64'd5},
    '{64'h3fff_ffff_ffff_ffff, 64'h8000_0000,    8'd0,  64'h7fff_ffff},    // 2^31
    '{64'hffff_ffff_ffff_ffff, 64'hffff_fffb,    8'd12, 64'd24}            // 2^64 = 25 mod m
  };

  logic              clk;
  logic              rst_n;
  logic              start;
  barrett_op_t       op;
  logic [DATA_W-1:0] result;
  logic              valid;
  logic              busy;

  vec_t              vec_tab [N_ROWS];
  logic [DATA_W-1:0] exp_q   [$];  // Scoreboard, oldest first
  int                start_q [$];  // Cycle of each start
  string             name_q  [$];
  logic [31:0]       rng;
  int                cyc        = 0;
  int                n_starts   = 0;
  int                n_valid    = 0;
  int                value_errs = 0;
  int                flag_errs  = 0;
  int                proto_errs = 0;

  `include "barrett_tb_util.svh"

  barrett_top barrett_top_inst (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .start_i  (start),
    .op_i     (op),
    .result_o (result),
    .valid_o  (valid),
    .busy_o   (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;  // Read only at falling edges

  // Directed rows, then random ones; first half of the random rows back to back
  task automatic fill_table();
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] m;
    int                width;
    for (int i = 0; i < N_DIR; i++) begin
      vec_tab[i] = DIR_TAB[i];
    end
    for (int i = 0; i < N_RAND; i++) begin
      rng   = xorshift32(rng);
      width = 2 + int'(rng % 32'd31);  // 2..32 bits
      rng   = xorshift32(rng);
      m     = {32'd0, rng} & ((64'd1 << width) - 64'd1);
      if (m < 64'd2) begin
        m = 64'd2;
      end
      rng       = xorshift32(rng);
      x[63:32]  = rng;
      rng       = xorshift32(rng);
      x[31:0]   = rng;
      x         = below_pow2(x, 2 * bit_length(m));
      vec_tab[N_DIR+i].x     = x;
      vec_tab[N_DIR+i].m     = m;
      vec_tab[N_DIR+i].gap   = (i < N_RAND / 2) ? 8'd0 : 8'(rng[1:0]);
      vec_tab[N_DIR+i].exp_r = ref_mod(x, m);
    end
  endtask

  // One strobe, then gap idle cycles with junk on op
  task automatic drive_row(input vec_t v, input string name);
    @(negedge clk);
    start  = 1'b1;
    op.x   = v.x;
    op.m   = v.m;
    op.mu  = barrett_mu(v.m);
    exp_q.push_back(v.exp_r);
    start_q.push_back(cyc);
    name_q.push_back(name);
    n_starts++;
    repeat (v.gap) begin
      @(negedge clk);
      start = 1'b0;
      op.x  = ~op.x;   // Must be ignored while start is low
      op.mu = ~op.mu;
    end
  endtask

  // Checks just after the falling edge, inputs and outputs both settled
  always @(negedge clk) begin : monitor
    string name;
    logic [DATA_W-1:0] exp_r;
    int s;
    #1;
    if (rst_n) begin
      check_flag("busy", exp_q.size() != 0, busy);  // Busy while anything outstanding
      if (valid) begin
        n_valid++;
        if (exp_q.size() == 0) begin
          $display("valid_o pulsed with no operation outstanding at cycle %0d", cyc);
          proto_errs++;
        end else begin
          name  = name_q.pop_front();
          exp_r = exp_q.pop_front();
          s     = start_q.pop_front();
          check_result(name, exp_r, result);
          check_result({name, " latency"}, DATA_W'(BARRETT_LATENCY), DATA_W'(cyc - s));
        end
      end else if (exp_q.size() != 0 && cyc - start_q[0] > BARRETT_LATENCY) begin
        name = name_q.pop_front();
        void'(exp_q.pop_front());
        void'(start_q.pop_front());
        $display("result for %s never appeared", name);
        proto_errs++;
      end
    end
  end

  initial begin
    string name;
    int    total;
    clk   = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    op    = '0;
    rng   = SEED;
    fill_table();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_flag("reset valid_o", 1'b0, valid);
    check_flag("reset busy_o", 1'b0, busy);
    check_result("reset result_o", '0, result);

    for (int i = 0; i < N_ROWS; i++) begin
      if (i < N_DIR) begin
        name = $sformatf("dir_%0d", i);
      end else begin
        name = $sformatf("rand_%0d", i - N_DIR);
      end
      drive_row(vec_tab[i], name);
    end
    @(negedge clk);
    start = 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);  // Pipeline empty, busy already low
    #2;
    check_flag("busy after drain", 1'b0, busy);
    check_result("valid count", DATA_W'(n_starts), DATA_W'(n_valid));

    total = value_errs + flag_errs + proto_errs;
    $display("errors: value %0d, flag %0d, protocol %0d", value_errs, flag_errs, proto_errs);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Run length bound from table size, worst gap and latency
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* design/barrett_top.sv */
// op_i sampled with start_i; result_o and valid_o BARRETT_LATENCY cycles later
// One start per cycle at most, results in order, valid_o must be taken at once
`timescale 1ns/100ps
`default_nettype none

module barrett_top import barrett_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  barrett_op_t       op_i,
  output logic [DATA_W-1:0] result_o,
  output logic              valid_o,
  output logic              busy_o
);

  stage_en_t         stage_en;
  barrett_op_t       op_q;       // Stage 0 output
  barrett_carry_t    carry_in;
  barrett_carry_t    carry_mid;  // Aligned with the q register
  barrett_carry_t    carry_out;  // Aligned with q*m
  logic [PROD_W-1:0] xmu;
  logic [PROD_W-1:0] qm;
  logic [DATA_W-1:0] q;

  barrett_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .stage_en_o (stage_en),
    .valid_o    (valid_o),
    .busy_o     (busy_o)
  );

  // Stage 0, input register
  delay_line #(.DEPTH(1), .WIDTH($bits(barrett_op_t))) u_op_line (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[0]),
    .data_i (op_i),
    .data_o (op_q)
  );

  // Stages 1..4, x * mu
  pipe_multiplier mult_xmu (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[MUL_STAGES:1]),
    .a_i    (op_q.x),
    .b_i    (op_q.mu),
    .p_o    (xmu)
  );

  assign carry_in.x = op_q.x;
  assign carry_in.m = op_q.m;

  // Stages 1..5, x and m beside multiplier A and the q register
  delay_line #(.DEPTH(MUL_STAGES + 1), .WIDTH($bits(barrett_carry_t))) u_carry_a (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[MUL_STAGES+1:1]),
    .data_i (carry_in),
    .data_o (carry_mid)
  );

  // Stage 5
  quotient_estimate u_qest (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[MUL_STAGES+1]),
    .prod_i (xmu),
    .m_i    (carry_mid.m),  // Loaded on the same edge as the product
    .q_o    (q)
  );

  // Stages 6..9, q * m
  pipe_multiplier mult_qm (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[2*MUL_STAGES+1:MUL_STAGES+2]),
    .a_i    (q),
    .b_i    (carry_mid.m),
    .p_o    (qm)
  );

  delay_line #(.DEPTH(MUL_STAGES), .WIDTH($bits(barrett_carry_t))) u_carry_b (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[2*MUL_STAGES+1:MUL_STAGES+2]),
    .data_i (carry_mid),
    .data_o (carry_out)
  );

  // Stage 10, final residue
  residue_correct u_resid (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (stage_en[2*MUL_STAGES+2]),
    .x_i    (carry_out.x),
    .m_i    (carry_out.m),
    .qm_i   (qm),
    .r_o    (result_o)
  );

endmodule

`default_nettype wire

/* design/barrett_ctrl.sv */
// Valid bits shift with their items; no stall, no back-pressure
// busy_o covers the start cycle up to and including the last valid_o
`timescale 1ns/100ps
`default_nettype none

module barrett_ctrl import barrett_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  output stage_en_t stage_en_o,
  output logic      valid_o,
  output logic      busy_o
);

  logic [BARRETT_LATENCY-2:0] live_q;  // Items headed for stages 1..10
  logic                       occupied;
  barrett_state_t             state_q;
  barrett_state_t             state_d;

  // One occupancy bit per item in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      live_q <= '0;
    end else begin
      live_q <= {live_q[BARRETT_LATENCY-3:0], start_i};
    end
  end

  assign stage_en_o = {live_q, start_i};  // Stage 0 works on the strobe cycle
  assign occupied   = |live_q;

  // Plain shift of the strobe, one bit per cycle
  delay_line #(
    .DEPTH (BARRETT_LATENCY),
    .WIDTH (1)
  ) u_valid_line (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   ('1),
    .data_i (start_i),
    .data_o (valid_o)
  );

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (!start_i) begin
          state_d = occupied ? DRAIN : IDLE;
        end
      end
      DRAIN: begin
        if (start_i) begin
          state_d = RUN;
        end else if (!occupied) begin
          state_d = IDLE;  // Last item leaves this cycle
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Registered state lags one cycle, so the strobe itself counts
  assign busy_o = start_i | (state_q != IDLE);

endmodule

`default_nettype wire

/* design/residue_correct.sv */
// Assumes x - q*m lies in [0, 3m), true for a correct mu
// Only the low word of q*m is used
`timescale 1ns/100ps
`default_nettype none

module residue_correct import barrett_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic [DATA_W-1:0] x_i,
  input  logic [DATA_W-1:0] m_i,
  input  logic [PROD_W-1:0] qm_i,  // q * m
  output logic [DATA_W-1:0] r_o
);

  logic [DATA_W-1:0] diff;   // Partial remainder
  logic [DATA_W-1:0] m2;
  logic [DATA_W-1:0] corr;   // 0, m or 2m
  logic [DATA_W-1:0] r_d;
  logic [DATA_W-1:0] r_q;

  // Exact modulo 2^DATA_W since the true difference is small
  assign diff = x_i - qm_i[DATA_W-1:0];
  assign m2   = {m_i[DATA_W-2:0], 1'b0};  // m < 2^32, no overflow

  always_comb begin
    if (diff >= m2) begin
      corr = m2;         // Two subtractions folded
    end else if (diff >= m_i) begin
      corr = m_i;
    end else begin
      corr = '0;         // Already reduced
    end
  end

  assign r_d = diff - corr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_q <= '0;         // result_o reads zero after reset
    end else if (en_i) begin
      r_q <= r_d;
    end
  end

  assign r_o = r_q;

endmodule

`default_nettype wire

/* design/quotient_estimate.sv */
// Registers x*mu, then shifts it right by 2k on the way out
// m_i must belong to the item now held in the product register
`timescale 1ns/100ps
`default_nettype none

module quotient_estimate import barrett_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic [PROD_W-1:0] prod_i,  // x * mu
  input  logic [DATA_W-1:0] m_i,
  output logic [DATA_W-1:0] q_o
);

  logic [PROD_W-1:0] prod_q;
  logic [K_W-1:0]    k;        // Bit length of m
  logic [K_W:0]      shamt;    // 2k
  logic [PROD_W-1:0] shifted;

  // Priority scan, highest set bit wins
  always_comb begin
    k = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (m_i[i]) begin
        k = K_W'(i + 1);
      end
    end
  end

  assign shamt = {k, 1'b0};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prod_q <= '0;
    end else if (en_i) begin
      prod_q <= prod_i;
    end
  end

  // floor(x*mu / 2^(2k))
  assign shifted = prod_q >> shamt;

  // x < 2^(2k) keeps q within a word
  assign q_o = shifted[DATA_W-1:0];

endmodule

`default_nettype wire

/* design/pipe_multiplier.sv */
// Unsigned DATA_W x DATA_W multiply in MUL_STAGES register stages
// New operand pair accepted every cycle; en_i[n] loads stage n
`timescale 1ns/100ps
`default_nettype none

module pipe_multiplier import barrett_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [MUL_STAGES-1:0] en_i,
  input  logic [DATA_W-1:0]     a_i,
  input  logic [DATA_W-1:0]     b_i,
  output logic [PROD_W-1:0]     p_o
);

  typedef logic [2*MUL_LIMB_W-1:0]      pp_t;    // One limb product
  typedef logic [DATA_W+MUL_LIMB_W-1:0] row_t;   // One a limb times all of b
  typedef logic [DATA_W+2*MUL_LIMB_W-1:0] pair_t; // Two adjacent rows

  pp_t   pp_q   [MUL_LIMBS][MUL_LIMBS];
  row_t  row_d  [MUL_LIMBS];
  row_t  row_q  [MUL_LIMBS];
  pair_t pair_d [MUL_LIMBS/2];
  pair_t pair_q [MUL_LIMBS/2];
  logic [PROD_W-1:0] p_d;
  logic [PROD_W-1:0] p_q;

  // Stage 0: sixteen 16x16 products
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MUL_LIMBS; i++) begin
        for (int j = 0; j < MUL_LIMBS; j++) begin
          pp_q[i][j] <= '0;
        end
      end
    end else if (en_i[0]) begin
      for (int i = 0; i < MUL_LIMBS; i++) begin
        for (int j = 0; j < MUL_LIMBS; j++) begin
          pp_q[i][j] <= pp_t'(a_i[i*MUL_LIMB_W +: MUL_LIMB_W])
                      * pp_t'(b_i[j*MUL_LIMB_W +: MUL_LIMB_W]);
        end
      end
    end
  end

  // Stage 1: row i = a limb i times b, four shifted products
  always_comb begin
    for (int i = 0; i < MUL_LIMBS; i++) begin
      row_d[i] = '0;
      for (int j = 0; j < MUL_LIMBS; j++) begin
        row_d[i] = row_d[i] + (row_t'(pp_q[i][j]) << (j * MUL_LIMB_W));
      end
    end
  end

  // Stage 2: neighbouring rows, odd row one limb up
  always_comb begin
    for (int r = 0; r < MUL_LIMBS / 2; r++) begin
      pair_d[r] = pair_t'(row_q[2*r]) + (pair_t'(row_q[2*r+1]) << MUL_LIMB_W);
    end
  end

  // Stage 3: upper pair sits two limbs up
  assign p_d = PROD_W'(pair_q[0]) + (PROD_W'(pair_q[1]) << (2 * MUL_LIMB_W));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MUL_LIMBS; i++) begin
        row_q[i] <= '0;
      end
      for (int r = 0; r < MUL_LIMBS / 2; r++) begin
        pair_q[r] <= '0;
      end
      p_q <= '0;
    end else begin
      if (en_i[1]) begin
        row_q <= row_d;
      end
      if (en_i[2]) begin
        pair_q <= pair_d;
      end
      if (en_i[3]) begin
        p_q <= p_d;  // Final add
      end
    end
  end

  assign p_o = p_q;

endmodule

`default_nettype wire

/* design/delay_line.sv */
// Register n loads only when en_i[n] is set, so bubbles keep old data
// All stages clear on reset
`timescale 1ns/100ps
`default_nettype none

module delay_line #(
  parameter int unsigned DEPTH = 1,
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [DEPTH-1:0] en_i,    // Per-stage load
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  // chain[0] is the input, chain[n+1] the output of register n
  logic [DEPTH:0][WIDTH-1:0] chain;

  assign chain[0] = data_i;

  for (genvar n = 0; n < DEPTH; n++) begin : g_stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        chain[n+1] <= '0;
      end else if (en_i[n]) begin
        chain[n+1] <= chain[n];  // Follow the item's valid bit
      end
    end
  end

  assign data_o = chain[DEPTH];  // Last register

endmodule

`default_nettype wire

/* design/barrett_pkg.sv */
// Moduli below 2^32 only; operands travel in 64-bit words
// mu is supplied by the caller, never computed here
`default_nettype none

package barrett_pkg;

  localparam int unsigned DATA_W     = 64;            // Operand word
  localparam int unsigned PROD_W     = 2 * DATA_W;    // Full product width
  localparam int unsigned MUL_STAGES = 4;             // Register stages per multiplier
  localparam int unsigned MUL_LIMB_W = 16;            // Partial product limb
  localparam int unsigned MUL_LIMBS  = DATA_W / MUL_LIMB_W;
  localparam int unsigned K_W        = $clog2(DATA_W + 1);  // Bit length 0..DATA_W

  // Input reg, multiplier A, q reg, multiplier B, residue reg
  // Result seen BARRETT_LATENCY cycles after the cycle start_i is high
  localparam int unsigned BARRETT_LATENCY = 2 * MUL_STAGES + 3;

  // One operation as presented by the caller
  typedef struct packed {
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] m;
    logic [DATA_W-1:0] mu;  // floor(2^(2k) / m)
  } barrett_op_t;

  // Carried next to the multipliers, mu is consumed by the first one
  typedef struct packed {
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] m;
  } barrett_carry_t;

  // Pipeline activity
  typedef enum logic [1:0] {
    IDLE,   // Nothing in flight
    RUN,    // Accepting on this cycle
    DRAIN   // No new start, items still moving
  } barrett_state_t;

  // Bit n set while stage n works on a live item
  typedef logic [BARRETT_LATENCY-1:0] stage_en_t;

endpackage

`default_nettype wire
